// File: source/tcp_tx_pkg.sv
`default_nettype none

package tcp_tx_pkg;

  localparam logic [7:0] tcp_proto = 8'd6; // ip protocol number

  localparam int min_hdr_len = 20; // bytes, no options
  localparam int opt_words   = 6;  // candidate option word slots
  localparam int max_opt_len = 24; // bytes, all options present

  // 13 summed halfwords, rest is load and handoff
  localparam logic [4:0] sum_cycles = 5'd16;

  // option kind bytes
  localparam logic [7:0] opt_end       = 8'd0;
  localparam logic [7:0] opt_nop       = 8'd1;
  localparam logic [7:0] opt_mss       = 8'd2;
  localparam logic [7:0] opt_win       = 8'd3;
  localparam logic [7:0] opt_sack_perm = 8'd4;
  localparam logic [7:0] opt_timestamp = 8'd8;

  // fields known when the request arrives
  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [31:0] seq_num;
    logic [31:0] ack_num;
    logic [8:0]  flags;       // ns..fin
    logic [15:0] win_size;
    logic [15:0] urg_ptr;
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [15:0] payload_len; // bytes
    logic [31:0] payload_sum; // unfolded, from the payload source
  } tcp_base_hdr_t;

  // option selections
  typedef struct packed {
    logic        mss_pres;
    logic [15:0] mss;
    logic        win_pres;
    logic [7:0]  win_shift;
    logic        sack_perm_pres;
    logic        ts_pres;
    logic [31:0] ts_val;
    logic [31:0] ts_ecr;
  } tcp_opt_sel_t;

endpackage

`default_nettype wire

// File: source/tcp_opt_if.sv
`default_nettype none

// option path, builder to serializer
interface tcp_opt_if;

  logic [0:tcp_tx_pkg::max_opt_len-1][7:0] opt_bytes; // byte 0 goes out first
  logic [4:0]  opt_len;  // bytes, multiple of 4
  logic [31:0] opt_sum;  // unfolded halfword sum
  logic        opt_done; // level, held until frame end

  modport builder (
    output opt_bytes, opt_len, opt_sum, opt_done
  );

  modport user (
    input opt_bytes, opt_len, opt_sum, opt_done
  );

endinterface

`default_nettype wire

// File: source/tcp_opt_builder.sv
`default_nettype none

module tcp_opt_builder (
  input  logic                     clk,
  input  logic                     fsm_rst,
  input  logic                     frame_end,
  input  logic                     start,
  input  tcp_tx_pkg::tcp_opt_sel_t sel,
  tcp_opt_if.builder               opt
);

  localparam int n_slots = tcp_tx_pkg::opt_words;

  logic                        rst;
  logic                        run;      // scanning slots
  logic [2:0]                  slot_cnt; // slot under test
  logic [0:n_slots-1][31:0]    cand;     // candidate words, slot 0 at the front
  logic [0:n_slots-1]          pres;     // present flag per slot

  assign rst = fsm_rst || frame_end; // clean up after every frame

  // control, length and sum
  always_ff @(posedge clk) begin
    if (rst) begin
      run          <= 1'b0;
      slot_cnt     <= '0;
      opt.opt_len  <= '0;
      opt.opt_sum  <= '0;
      opt.opt_done <= 1'b0;
    end else if (start) begin
      run          <= 1'b1;
      slot_cnt     <= '0;
      opt.opt_len  <= '0;
      opt.opt_sum  <= '0;
      opt.opt_done <= 1'b0;
    end else if (run) begin
      slot_cnt <= slot_cnt + 3'd1;
      if (pres[0]) begin // word kept, count it and sum both halves
        opt.opt_len <= opt.opt_len + 5'd4;
        opt.opt_sum <= opt.opt_sum + cand[0][31:16] + cand[0][15:0];
      end
      if (slot_cnt == 3'(n_slots - 1)) begin // last slot seen
        run          <= 1'b0;
        opt.opt_done <= 1'b1;
      end
    end
  end

  // candidate words and the packed option bytes
  always_ff @(posedge clk) begin
    if (start) begin
      cand <= {
        {tcp_tx_pkg::opt_mss, 8'd4, sel.mss},
        {tcp_tx_pkg::opt_nop, tcp_tx_pkg::opt_win, 8'd3, sel.win_shift},
        {tcp_tx_pkg::opt_nop, tcp_tx_pkg::opt_nop, tcp_tx_pkg::opt_sack_perm, 8'd2},
        {tcp_tx_pkg::opt_nop, tcp_tx_pkg::opt_nop, tcp_tx_pkg::opt_timestamp, 8'd10},
        sel.ts_val,
        sel.ts_ecr
      };
      pres <= {
        sel.mss_pres,
        sel.win_pres,
        sel.sack_perm_pres,
        {3{sel.ts_pres}} // kind word, value, echo
      };
      opt.opt_bytes <= {tcp_tx_pkg::max_opt_len{tcp_tx_pkg::opt_end}}; // unused bytes stay zero
    end else if (run) begin
      cand[0:n_slots-2] <= cand[1:n_slots-1]; // next slot to the front
      pres[0:n_slots-2] <= pres[1:n_slots-1];
      if (pres[0]) opt.opt_bytes[opt.opt_len +: 4] <= cand[0]; // append after last word
    end
  end

endmodule

`default_nettype wire

// File: source/tcp_hdr_sum.sv
`default_nettype none

module tcp_hdr_sum (
  input  logic                      clk,
  input  logic                      fsm_rst,
  input  logic                      frame_end,
  input  logic                      start,
  input  tcp_tx_pkg::tcp_base_hdr_t hdr,
  output logic [31:0]               base_sum,
  output logic                      sum_done
);

  // pseudo header without length: 5, header without offset/flags and checksum: 8
  localparam int n_hw = 13;

  logic                   rst;
  logic                   run;
  logic [4:0]             cyc_cnt; // cycles since load
  logic [0:n_hw-1][15:0]  hw_sr;   // halfwords, next one at index 0

  assign rst = fsm_rst || frame_end;

  always_ff @(posedge clk) begin
    if (rst) begin
      run      <= 1'b0;
      cyc_cnt  <= '0;
      base_sum <= '0;
      sum_done <= 1'b0;
    end else if (start) begin
      run      <= 1'b1;
      cyc_cnt  <= 5'd1;
      base_sum <= '0;
      sum_done <= 1'b0;
    end else if (run) begin
      cyc_cnt <= cyc_cnt + 5'd1;
      if (cyc_cnt <= 5'(n_hw)) base_sum <= base_sum + {16'd0, hw_sr[0]}; // one halfword per cycle
      if (cyc_cnt == tcp_tx_pkg::sum_cycles - 5'd1) begin // lines up with the serializer
        run      <= 1'b0;
        sum_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      hw_sr <= {
        hdr.src_ip,
        hdr.dst_ip,
        {8'h00, tcp_tx_pkg::tcp_proto}, // zero, protocol
        hdr.src_port,
        hdr.dst_port,
        hdr.seq_num,
        hdr.ack_num,
        hdr.win_size,
        hdr.urg_ptr
      };
    end else if (run) begin
      hw_sr[0:n_hw-2] <= hw_sr[1:n_hw-1];
    end
  end

endmodule

`default_nettype wire

// File: source/tcp_tx_serializer.sv
`default_nettype none

module tcp_tx_serializer #(
  parameter int queue_addr_w = 10
) (
  input  logic                      clk,
  input  logic                      fsm_rst,
  input  logic                      start,
  input  tcp_tx_pkg::tcp_base_hdr_t hdr,
  tcp_opt_if.user                   opt,
  input  logic [31:0]               base_sum,
  input  logic                      sum_done,
  input  logic [7:0]                queue_data,
  output logic                      queue_req,
  output logic [queue_addr_w-1:0]   queue_addr,
  output logic                      tx_v,
  output logic                      tx_sof,
  output logic                      tx_eof,
  output logic [7:0]                tx_d,
  output logic                      frame_end
);

  localparam int hdr_bytes = tcp_tx_pkg::min_hdr_len + tcp_tx_pkg::max_opt_len; // 44

  logic                       rst;
  logic                       armed;   // request seen, waiting for partial sums
  logic                       added;   // sum_acc valid
  logic                       folded;  // chsum valid
  logic                       sending;
  logic                       pay_sel; // tx_d from the queue
  logic [3:0]                 data_off;
  logic [15:0]                offs_flags;
  logic [15:0]                hdr_len_c;
  logic [15:0]                tcp_len_c;
  logic [15:0]                hdr_len;  // header plus options
  logic [15:0]                tcp_len;  // whole segment
  logic [15:0]                byte_cnt; // index of byte on tx_d
  logic [31:0]                sum_acc;
  logic [16:0]                fold;
  logic [15:0]                chsum;
  logic [0:hdr_bytes-1][7:0]  hdr_sr;

  assign rst       = fsm_rst || tx_eof; // last byte ends the frame
  assign frame_end = tx_eof;

  assign data_off   = 4'(tcp_tx_pkg::min_hdr_len / 4) + {1'b0, opt.opt_len[4:2]};
  assign offs_flags = {data_off, 3'b000, hdr.flags};
  assign hdr_len_c  = 16'(tcp_tx_pkg::min_hdr_len) + {11'd0, opt.opt_len};
  assign tcp_len_c  = hdr_len_c + hdr.payload_len;
  assign fold       = {1'b0, sum_acc[31:16]} + {1'b0, sum_acc[15:0]}; // first carry fold

  assign tx_d = pay_sel ? queue_data : hdr_sr[0];

  always_ff @(posedge clk) begin
    if (rst) begin
      armed      <= 1'b0;
      added      <= 1'b0;
      folded     <= 1'b0;
      sending    <= 1'b0;
      pay_sel    <= 1'b0;
      tx_v       <= 1'b0;
      tx_sof     <= 1'b0;
      tx_eof     <= 1'b0;
      queue_req  <= 1'b0;
      queue_addr <= '0;
      byte_cnt   <= '0;
    end else begin
      if (start) begin
        armed      <= 1'b1;
        queue_addr <= hdr.seq_num[queue_addr_w-1:0]; // payload sits at seq low bits
      end else if (queue_req) begin
        queue_addr <= queue_addr + 1'b1;
      end
      pay_sel <= queue_req; // data back one cycle after its address
      if (armed && opt.opt_done && sum_done) begin
        armed <= 1'b0;
        added <= 1'b1;
      end
      if (added) begin
        added  <= 1'b0;
        folded <= 1'b1;
      end
      if (folded) begin // header register loaded now
        folded   <= 1'b0;
        sending  <= 1'b1;
        tx_v     <= 1'b1;
        tx_sof   <= 1'b1;
        byte_cnt <= '0;
      end else if (sending) begin
        tx_sof   <= 1'b0;
        byte_cnt <= byte_cnt + 16'd1;
        // fetch one ahead of the first payload byte
        if (byte_cnt == hdr_len - 16'd2 && hdr.payload_len != '0) queue_req <= 1'b1;
        if (byte_cnt == tcp_len - 16'd2) begin // next byte is the last
          queue_req <= 1'b0;
          tx_eof    <= 1'b1;
        end
      end
    end
  end

  // checksum pipeline, two cycles
  always_ff @(posedge clk) begin
    if (armed && opt.opt_done && sum_done) begin
      sum_acc <= base_sum + opt.opt_sum + hdr.payload_sum +
                 {16'd0, tcp_len_c} + {16'd0, offs_flags};
      hdr_len <= hdr_len_c;
      tcp_len <= tcp_len_c;
    end
    if (added) chsum <= ~(fold[15:0] + {15'd0, fold[16]}); // second fold cannot carry
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hdr_sr <= '0; // keeps tx_d at zero when idle
    end else if (folded) begin
      hdr_sr <= {
        hdr.src_port,
        hdr.dst_port,
        hdr.seq_num,
        hdr.ack_num,
        offs_flags,
        hdr.win_size,
        chsum,
        hdr.urg_ptr,
        opt.opt_bytes
      };
    end else if (sending) begin
      hdr_sr[0:hdr_bytes-2] <= hdr_sr[1:hdr_bytes-1]; // one byte per cycle
      hdr_sr[hdr_bytes-1]   <= 8'h00;
    end
  end

endmodule

`default_nettype wire

// File: source/tcp_tx.sv
`default_nettype none

module tcp_tx #(
  parameter int queue_addr_w = 10
) (
  input  logic                    clk,
  input  logic                    fsm_rst,
  input  logic                    hdr_v,
  input  logic [15:0]             src_port,
  input  logic [15:0]             dst_port,
  input  logic [31:0]             seq_num,
  input  logic [31:0]             ack_num,
  input  logic [8:0]              flags,
  input  logic [15:0]             win_size,
  input  logic [15:0]             urg_ptr,
  input  logic [31:0]             src_ip,
  input  logic [31:0]             dst_ip,
  input  logic [15:0]             payload_len,
  input  logic [31:0]             payload_sum,
  input  logic                    mss_pres,
  input  logic [15:0]             mss,
  input  logic                    win_pres,
  input  logic [7:0]              win_shift,
  input  logic                    sack_perm_pres,
  input  logic                    ts_pres,
  input  logic [31:0]             ts_val,
  input  logic [31:0]             ts_ecr,
  input  logic [7:0]              queue_data,
  output logic                    busy,
  output logic                    queue_req,
  output logic [queue_addr_w-1:0] queue_addr,
  output logic                    tx_v,
  output logic                    tx_sof,
  output logic                    tx_eof,
  output logic [7:0]              tx_d
);

  tcp_tx_pkg::tcp_base_hdr_t hdr_q; // request held for the whole frame
  tcp_tx_pkg::tcp_opt_sel_t  sel_q;
  logic                      accept;
  logic                      start;
  logic                      frame_end;
  logic [31:0]               base_sum;
  logic                      sum_done;

  tcp_opt_if opt_bus ();

  assign accept = hdr_v && !busy; // requests while busy are dropped

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      busy  <= 1'b0;
      start <= 1'b0;
    end else begin
      start <= accept; // single pulse to all three parts
      if (accept) busy <= 1'b1;
      else if (frame_end) busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      hdr_q.src_port       <= src_port;
      hdr_q.dst_port       <= dst_port;
      hdr_q.seq_num        <= seq_num;
      hdr_q.ack_num        <= ack_num;
      hdr_q.flags          <= flags;
      hdr_q.win_size       <= win_size;
      hdr_q.urg_ptr        <= urg_ptr;
      hdr_q.src_ip         <= src_ip;
      hdr_q.dst_ip         <= dst_ip;
      hdr_q.payload_len    <= payload_len;
      hdr_q.payload_sum    <= payload_sum;
      sel_q.mss_pres       <= mss_pres;
      sel_q.mss            <= mss;
      sel_q.win_pres       <= win_pres;
      sel_q.win_shift      <= win_shift;
      sel_q.sack_perm_pres <= sack_perm_pres;
      sel_q.ts_pres        <= ts_pres;
      sel_q.ts_val         <= ts_val;
      sel_q.ts_ecr         <= ts_ecr;
    end
  end

  tcp_opt_builder u_opt_builder (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .frame_end (frame_end),
    .start     (start),
    .sel       (sel_q),
    .opt       (opt_bus.builder)
  );

  tcp_hdr_sum u_hdr_sum (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .frame_end (frame_end),
    .start     (start),
    .hdr       (hdr_q),
    .base_sum  (base_sum),
    .sum_done  (sum_done)
  );

  tcp_tx_serializer #(
    .queue_addr_w (queue_addr_w)
  ) u_serializer (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .start      (start),
    .hdr        (hdr_q),
    .opt        (opt_bus.user),
    .base_sum   (base_sum),
    .sum_done   (sum_done),
    .queue_data (queue_data),
    .queue_req  (queue_req),
    .queue_addr (queue_addr),
    .tx_v       (tx_v),
    .tx_sof     (tx_sof),
    .tx_eof     (tx_eof),
    .tx_d       (tx_d),
    .frame_end  (frame_end)
  );

endmodule

`default_nettype wire

// File: verification/tcp_tx_tb.sv
`default_nettype none

module tcp_tx_tb;

  localparam int addr_w       = 10;
  localparam int mem_size     = 1 << addr_w;
  localparam int max_pay      = 64;
  localparam int max_frame    = 128;                    // 44 header bytes plus payload
  localparam int n_rand       = 40;
  localparam int n_frames     = n_rand + 5;             // directed frames too
  localparam int frame_budget = 19 + 44 + max_pay + 10; // worst case cycles per frame

  typedef tcp_tx_pkg::tcp_base_hdr_t hdr_t;
  typedef tcp_tx_pkg::tcp_opt_sel_t  sel_t;
  typedef logic [7:0] frame_t [0:max_frame-1];

  logic              clk;
  logic              fsm_rst;
  logic              hdr_v;
  hdr_t              hdr_in; // drives the plain header ports
  sel_t              sel_in;
  logic [7:0]        queue_data;
  logic              busy;
  logic              queue_req;
  logic [addr_w-1:0] queue_addr;
  logic              tx_v;
  logic              tx_sof;
  logic              tx_eof;
  logic [7:0]        tx_d;

  logic [7:0]        mem [0:mem_size-1]; // payload queue contents

  // expected frame from the sequence to the monitor
  frame_t            exp_bytes;
  int                exp_len;
  int                exp_pay_len;
  logic [addr_w-1:0] exp_qbase;
  logic              exp_active;
  int                frames_seen;
  int                frames_sent;
  int                cyc = 0;
  int                req_cyc;   // edge where the request was taken
  int                byte_idx;
  int                q_cnt;     // queue reads in this frame
  logic              after_eof;
  logic              busy_due;  // accepted frame not yet ended

  tcp_tx #(
    .queue_addr_w (addr_w)
  ) u_dut (
    .clk            (clk),
    .fsm_rst        (fsm_rst),
    .hdr_v          (hdr_v),
    .src_port       (hdr_in.src_port),
    .dst_port       (hdr_in.dst_port),
    .seq_num        (hdr_in.seq_num),
    .ack_num        (hdr_in.ack_num),
    .flags          (hdr_in.flags),
    .win_size       (hdr_in.win_size),
    .urg_ptr        (hdr_in.urg_ptr),
    .src_ip         (hdr_in.src_ip),
    .dst_ip         (hdr_in.dst_ip),
    .payload_len    (hdr_in.payload_len),
    .payload_sum    (hdr_in.payload_sum),
    .mss_pres       (sel_in.mss_pres),
    .mss            (sel_in.mss),
    .win_pres       (sel_in.win_pres),
    .win_shift      (sel_in.win_shift),
    .sack_perm_pres (sel_in.sack_perm_pres),
    .ts_pres        (sel_in.ts_pres),
    .ts_val         (sel_in.ts_val),
    .ts_ecr         (sel_in.ts_ecr),
    .queue_data     (queue_data),
    .busy           (busy),
    .queue_req      (queue_req),
    .queue_addr     (queue_addr),
    .tx_v           (tx_v),
    .tx_sof         (tx_sof),
    .tx_eof         (tx_eof),
    .tx_d           (tx_d)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // queue model answers one cycle after the address
  always @(posedge clk) begin
    if (queue_req) queue_data <= mem[queue_addr];
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
      stop_run($sformatf("Fail at %0t: %s is %0h, expected %0h", $time, what, got, exp));
  endtask

  // halfword sum of the payload in the queue with the odd byte padded low
  function automatic logic [31:0] payload_sum_of(input logic [31:0] seq, input int len);
    logic [31:0] s;
    logic [7:0]  hi;
    logic [7:0]  lo;
    s = '0;
    for (int i = 0; i < len; i += 2) begin
      hi = mem[(int'(seq[addr_w-1:0]) + i) % mem_size];
      lo = (i + 1 < len) ? mem[(int'(seq[addr_w-1:0]) + i + 1) % mem_size] : 8'h00;
      s += {16'd0, hi, lo};
    end
    return s;
  endfunction

  // builds the expected segment and returns its length
  function automatic int ref_frame(input hdr_t h, input sel_t s, output frame_t f);
    int          n;
    int          olen;
    logic [31:0] sum;
    for (int i = 0; i < max_frame; i++) f[i] = 8'h00;
    {f[0], f[1]}             = h.src_port;
    {f[2], f[3]}             = h.dst_port;
    {f[4], f[5], f[6], f[7]} = h.seq_num;
    {f[8], f[9], f[10], f[11]} = h.ack_num;
    {f[14], f[15]}           = h.win_size;
    {f[18], f[19]}           = h.urg_ptr; // checksum bytes 16 and 17 stay zero for now
    n = 20;
    if (s.mss_pres) begin
      {f[n], f[n+1], f[n+2], f[n+3]} = {8'd2, 8'd4, s.mss};
      n += 4;
    end
    if (s.win_pres) begin // nop pads to a word
      {f[n], f[n+1], f[n+2], f[n+3]} = {8'd1, 8'd3, 8'd3, s.win_shift};
      n += 4;
    end
    if (s.sack_perm_pres) begin
      {f[n], f[n+1], f[n+2], f[n+3]} = {8'd1, 8'd1, 8'd4, 8'd2};
      n += 4;
    end
    if (s.ts_pres) begin
      {f[n], f[n+1], f[n+2], f[n+3]}   = {8'd1, 8'd1, 8'd8, 8'd10};
      {f[n+4], f[n+5], f[n+6], f[n+7]} = s.ts_val;
      {f[n+8], f[n+9], f[n+10], f[n+11]} = s.ts_ecr;
      n += 12;
    end
    olen = n - 20;
    {f[12], f[13]} = {4'(5 + olen / 4), 3'b000, h.flags}; // data offset in words
    for (int i = 0; i < int'(h.payload_len); i++)
      f[n + i] = mem[(int'(h.seq_num[addr_w-1:0]) + i) % mem_size];
    n += int'(h.payload_len);
    // pseudo header with the tcp length
    sum = {16'd0, h.src_ip[31:16]} + {16'd0, h.src_ip[15:0]} +
          {16'd0, h.dst_ip[31:16]} + {16'd0, h.dst_ip[15:0]} + 32'd6 + 32'(n);
    for (int i = 0; i < n; i += 2) sum += {16'd0, f[i], f[i + 1]}; // f[n] is zero
    while (sum[31:16] != 16'd0) sum = {16'd0, sum[31:16]} + {16'd0, sum[15:0]};
    {f[16], f[17]} = ~sum[15:0];
    return n;
  endfunction

  task automatic random_request(output hdr_t h, output sel_t s);
    h.src_port    = 16'($urandom);
    h.dst_port    = 16'($urandom);
    h.seq_num     = $urandom;
    h.ack_num     = $urandom;
    h.flags       = 9'($urandom);
    h.win_size    = 16'($urandom);
    h.urg_ptr     = 16'($urandom);
    h.src_ip      = $urandom;
    h.dst_ip      = $urandom;
    h.payload_len = 16'($urandom_range(0, max_pay));
    h.payload_sum = payload_sum_of(h.seq_num, int'(h.payload_len));
    s.mss_pres       = 1'($urandom);
    s.mss            = 16'($urandom);
    s.win_pres       = 1'($urandom);
    s.win_shift      = 8'($urandom);
    s.sack_perm_pres = 1'($urandom);
    s.ts_pres        = 1'($urandom);
    s.ts_val         = $urandom;
    s.ts_ecr         = $urandom;
  endtask

  task automatic drive_request(input hdr_t h, input sel_t s);
    @(posedge clk);
    hdr_v  <= 1'b1;
    hdr_in <= h;
    sel_in <= s;
    @(posedge clk);
    hdr_v <= 1'b0;
  endtask

  // arms the monitor, then drives
  task automatic send_request(input hdr_t h, input sel_t s);
    h.payload_sum = payload_sum_of(h.seq_num, int'(h.payload_len));
    exp_len     = ref_frame(h, s, exp_bytes);
    exp_pay_len = int'(h.payload_len);
    exp_qbase   = h.seq_num[addr_w-1:0];
    exp_active  = 1'b1;
    drive_request(h, s);
  endtask

  task automatic wait_frames(input int n);
    while (frames_seen < n) @(posedge clk);
    repeat (2) @(posedge clk); // idle gap
  endtask

  // compare process on the falling edge
  always @(negedge clk) begin
    if (fsm_rst) begin
      exp_active = 1'b0; // frame cut short
      byte_idx   = 0;
      q_cnt      = 0;
      after_eof  = 1'b0;
      busy_due   = 1'b0;
    end else begin
      if (after_eof) begin
        check_val(busy, 0, "busy after tx_eof");
        check_val(tx_v, 0, "tx_v after tx_eof");
        check_val(tx_eof, 0, "tx_eof held");
        after_eof = 1'b0;
      end
      if (busy_due) check_val(busy, 1, "busy while a frame is pending");
      if (hdr_v && !busy) begin // taken at the next edge
        req_cyc  = cyc + 1;
        busy_due = 1'b1;
      end
      if (queue_req) begin
        check_val(queue_addr, addr_w'(exp_qbase + q_cnt), "queue_addr");
        q_cnt++;
      end
      if (tx_v) begin
        if (!exp_active) stop_run("tx_v went high with no request outstanding");
        if (byte_idx == 0) check_val(cyc - req_cyc, 19, "cycles from request to tx_sof");
        check_val(tx_sof, byte_idx == 0, "tx_sof");
        check_val(tx_d, exp_bytes[byte_idx], $sformatf("tx_d byte %0d", byte_idx));
        check_val(tx_eof, byte_idx == exp_len - 1, "tx_eof");
        byte_idx++;
        if (tx_eof) begin
          check_val(q_cnt, exp_pay_len, "queue read count");
          frames_seen++;
          exp_active = 1'b0;
          byte_idx   = 0;
          q_cnt      = 0;
          after_eof  = 1'b1;
          busy_due   = 1'b0;
        end
      end else begin
        if (byte_idx != 0) stop_run("tx_v dropped in the middle of a frame");
        if (tx_sof || tx_eof) stop_run("tx_sof or tx_eof seen without tx_v");
      end
    end
  end

  // watchdog
  initial begin
    repeat (n_frames * frame_budget + 20) @(posedge clk);
    stop_run("timeout, the test sequence did not finish in time");
  end

  initial begin
    hdr_t h;
    hdr_t h2;
    sel_t s;
    sel_t s2;
    fsm_rst     = 1'b1;
    hdr_v       = 1'b0;
    hdr_in      = '0;
    sel_in      = '0;
    queue_data  = 8'h00;
    exp_active  = 1'b0;
    frames_seen = 0;
    frames_sent = 0;
    byte_idx    = 0;
    q_cnt       = 0;
    after_eof   = 1'b0;
    busy_due    = 1'b0;
    void'($urandom(32'he8e4_01e0));
    for (int i = 0; i < mem_size; i++) mem[i] = 8'($urandom);
    repeat (3) @(posedge clk);
    fsm_rst <= 1'b0;
    @(negedge clk);
    check_val(busy, 0, "busy after reset");
    check_val(tx_v, 0, "tx_v after reset");
    check_val(tx_sof, 0, "tx_sof after reset");
    check_val(tx_eof, 0, "tx_eof after reset");
    check_val(queue_req, 0, "queue_req after reset");
    check_val(tx_d, 0, "tx_d after reset");

    // bare 20 byte header
    random_request(h, s);
    h.payload_len = '0;
    s = '0;
    send_request(h, s);
    wait_frames(++frames_sent);

    // every option gives a 44 byte header
    random_request(h, s);
    h.payload_len    = '0;
    s.mss_pres       = 1'b1;
    s.win_pres       = 1'b1;
    s.sack_perm_pres = 1'b1;
    s.ts_pres        = 1'b1;
    send_request(h, s);
    wait_frames(++frames_sent);

    for (int k = 0; k < n_rand; k++) begin
      random_request(h, s);
      send_request(h, s);
      wait_frames(++frames_sent);
    end

    // requests while busy are dropped
    random_request(h, s);
    h.payload_len = 16'd16;
    send_request(h, s);
    frames_sent++;
    repeat (4) @(posedge clk);
    for (int k = 0; k < 3; k++) begin
      random_request(h2, s2);
      drive_request(h2, s2);
      repeat (5) @(posedge clk);
    end
    wait_frames(frames_sent);
    repeat (30) @(posedge clk); // a second frame would trip the monitor

    // reset inside the payload
    random_request(h, s);
    h.payload_len    = 16'd48;
    s.mss_pres       = 1'b1;
    s.win_pres       = 1'b1;
    s.sack_perm_pres = 1'b1;
    s.ts_pres        = 1'b1;
    send_request(h, s);
    while (byte_idx < 50) @(posedge clk);
    fsm_rst <= 1'b1;
    @(posedge clk);
    fsm_rst <= 1'b0;
    @(negedge clk);
    check_val(busy, 0, "busy after mid-frame reset");
    check_val(tx_v, 0, "tx_v after mid-frame reset");
    check_val(tx_eof, 0, "tx_eof after mid-frame reset");
    check_val(queue_req, 0, "queue_req after mid-frame reset");
    random_request(h, s);
    send_request(h, s);
    wait_frames(++frames_sent);

    if (frames_seen == frames_sent) begin
      $display("All tests passed");
      $finish;
    end else begin
      stop_run("frames missing at the end of the run");
    end
  end

endmodule

`default_nettype wire

// File: list.f
source/tcp_tx_pkg.sv
source/tcp_opt_if.sv
source/tcp_opt_builder.sv
source/tcp_hdr_sum.sv
source/tcp_tx_serializer.sv
source/tcp_tx.sv
verification/tcp_tx_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tcp_tx_tb
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all lint clean

all:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "All tests passed" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
